/* qla_pkg.sv */
// motor-controller board shared definitions
// address map of the host register bus, write bus and command types,
// serial DAC frame constants and the board status word layout
`default_nettype none

package qla_pkg;

    // --------------------
    // address map
    // --------------------
    localparam int num_chan = 4;

    // address spaces and register offsets
    localparam logic [3:0] addr_main     = 4'd0;
    localparam logic [3:0] reg_status    = 4'd0;
    localparam logic [3:0] reg_timestamp = 4'd10;
    localparam logic [3:0] off_dac_ctrl  = 4'd1;

    // space | reserved | chan | offset
    typedef struct packed {
        logic [3:0] space;
        logic [3:0] rsvd;
        logic [3:0] chan;
        logic [3:0] offset;
    } addr_t;

    // host write bus of 50 bits
    typedef struct packed {
        addr_t       waddr;
        logic [31:0] wdata;
        logic        wen;
        logic        blk_wen;
    } wr_bus_t;

    // commanded current per channel with index 0 for channel 1
    typedef logic [15:0] cur_cmd_t;
    typedef cur_cmd_t [num_chan-1:0] cmd_set_t;

    // --------------------
    // DAC frame
    // --------------------
    localparam logic [3:0] dac_cmd_write_update = 4'b0011;
    localparam int dac_frame_bits = 24;
    localparam int dac_gap_cycles = 2;
    localparam int dac_valid_bit  = 31;

    // --------------------
    // status register
    // --------------------
    // mask and value positions of a status write
    localparam int pwr_mask_bit  = 19;
    localparam int pwr_value_bit = 18;
    localparam int amp_mask_lsb  = 8;
    localparam int amp_value_lsb = 0;

    typedef struct packed {
        logic [3:0] rsvd_31_28;
        logic [3:0] board_id;
        logic       wdog_timeout;
        logic [5:0] rsvd_22_17;
        logic       pwr_enable;
        logic [3:0] rsvd_15_12;
        logic [3:0] amp_fault;
        logic [3:0] rsvd_7_4;
        logic [3:0] amp_enable;
    } status_t;

endpackage

`default_nettype wire

/* cmd_bank.sv */
// commanded-current register bank
// holds one command word per motor channel and decides when the
// serial DAC gets a new update; single writes update at once, block
// writes collect commands and start one update on blk_wen
`timescale 1ns/1ns
`default_nettype none

module cmd_bank (
    input  logic              sysclk,
    input  logic              rst_n,
    input  qla_pkg::wr_bus_t  wr,
    input  logic              dac_busy,
    output qla_pkg::cmd_set_t cur_cmd,
    output logic              data_ready
);

    logic main_space;
    logic dac_addr;
    logic status_addr;
    logic cmd_valid;
    // a valid command came in during the current block write
    logic dac_pending;
    // update waiting for the shifter to go idle
    logic dac_req;

    // --------------------
    // address decode
    // --------------------
    assign main_space = (wr.waddr.space == qla_pkg::addr_main);

    // only channels 1 to num_chan carry a command register
    assign dac_addr = main_space
                      && (wr.waddr.chan >= 4'd1)
                      && (wr.waddr.chan <= 4'(qla_pkg::num_chan))
                      && (wr.waddr.offset == qla_pkg::off_dac_ctrl);

    // last word of a block write goes to the channel 0 status register
    assign status_addr = main_space
                         && (wr.waddr.chan == 4'd0)
                         && (wr.waddr.offset == qla_pkg::reg_status);

    // bit 31 marks the command word as valid
    assign cmd_valid = dac_addr && wr.wen && wr.wdata[qla_pkg::dac_valid_bit];

    // --------------------
    // command registers
    // --------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            cur_cmd <= '0;
        end else begin
            for (int i = 0; i < qla_pkg::num_chan; i++) begin
                if (cmd_valid && (wr.waddr.chan == 4'(i + 1))) begin
                    cur_cmd[i] <= wr.wdata[15:0];
                end
            end
        end
    end

    // --------------------
    // update request
    // --------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            dac_pending <= 1'b0;
            dac_req     <= 1'b0;
            data_ready  <= 1'b0;
        end else begin
            if (wr.wen && (dac_addr || status_addr)) begin
                if (wr.blk_wen) begin
                    // end of block, or a single write with blk_wen alongside
                    dac_pending <= 1'b0;
                    if (dac_pending || cmd_valid) begin
                        // hold as request while the shifter is busy, else start now
                        dac_req    <= dac_busy;
                        data_ready <= ~dac_busy;
                    end
                end else if (cmd_valid) begin
                    dac_pending <= 1'b1;
                end
            end
            // hand the held request over once the shifter is idle
            if (dac_req && !dac_busy) begin
                dac_req    <= 1'b0;
                data_ready <= 1'b1;
            end else if (data_ready && dac_busy) begin
                // shifter took the commands
                data_ready <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* board_status.sv */
// board status block
// free-running timestamp, power and amplifier enable registers with
// bit masks, status word assembly and the watchdog-clear pulse
`timescale 1ns/1ns
`default_nettype none

module board_status (
    input  logic             sysclk,
    input  logic             rst_n,
    input  qla_pkg::wr_bus_t wr,
    input  logic [3:0]       board_id,
    input  logic [3:0]       amp_fault,
    input  logic             wdog_timeout,
    output qla_pkg::status_t status,
    output logic [31:0]      timestamp,
    output logic             wdog_clear
);

    logic       status_wr;
    logic       pwr_mask;
    logic       pwr_value;
    logic [3:0] amp_mask;
    logic [3:0] amp_value;
    logic       pwr_enable;
    logic [3:0] amp_enable;

    // write to chan 0 status register
    assign status_wr = wr.wen
                       && (wr.waddr.space == qla_pkg::addr_main)
                       && (wr.waddr.chan == 4'd0)
                       && (wr.waddr.offset == qla_pkg::reg_status);

    // mask and value fields of the written word
    assign pwr_mask  = wr.wdata[qla_pkg::pwr_mask_bit];
    assign pwr_value = wr.wdata[qla_pkg::pwr_value_bit];
    assign amp_mask  = wr.wdata[qla_pkg::amp_mask_lsb +: qla_pkg::num_chan];
    assign amp_value = wr.wdata[qla_pkg::amp_value_lsb +: qla_pkg::num_chan];

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            timestamp  <= '0;
            pwr_enable <= 1'b0;
            amp_enable <= '0;
            wdog_clear <= 1'b0;
        end else begin
            timestamp <= timestamp + 32'd1;
            if (status_wr && pwr_mask) begin
                pwr_enable <= pwr_value;
            end
            if (status_wr) begin
                // only masked bits change
                amp_enable <= (amp_enable & ~amp_mask) | (amp_value & amp_mask);
            end
            // host tries to switch something on, so clear the watchdog flag
            wdog_clear <= status_wr && ((pwr_mask && pwr_value) || |(amp_mask & amp_value));
        end
    end

    // --------------------
    // status word
    // --------------------
    always_comb begin
        status              = '0;
        status.board_id     = board_id;
        status.wdog_timeout = wdog_timeout;
        status.pwr_enable   = pwr_enable;
        status.amp_fault    = amp_fault;
        status.amp_enable   = amp_enable;
    end

endmodule

`default_nettype wire

/* dac_shifter.sv */
// serial DAC shifter
// latches the four channel commands and sends one 24-bit frame per
// channel, MSB first: command code, channel index, command word;
// sclk runs at half the system clock, each frame ends with an idle gap
`timescale 1ns/1ns
`default_nettype none

module dac_shifter (
    input  logic              sysclk,
    input  logic              rst_n,
    input  qla_pkg::cmd_set_t cur_cmd,
    input  logic              data_ready,
    output logic              busy,
    output logic              sclk,
    output logic              mosi,
    output logic              csel
);

    qla_pkg::cmd_set_t                 cmd_lat;
    logic [1:0]                        frame;
    // cycle within a frame counting bit phases then gap
    logic [5:0]                        cyc;
    logic [qla_pkg::dac_frame_bits-1:0] shreg;
    logic                              in_frame;
    logic                              frame_end;

    // frame word for one channel
    function automatic logic [qla_pkg::dac_frame_bits-1:0] make_frame(
        input qla_pkg::cur_cmd_t cmd,
        input logic [1:0]        idx
    );
        make_frame = {qla_pkg::dac_cmd_write_update, 2'b00, idx, cmd};
    endfunction

    // two cycles per bit
    assign in_frame  = busy && (cyc < 6'(2 * qla_pkg::dac_frame_bits));
    assign frame_end = (cyc == 6'(2 * qla_pkg::dac_frame_bits + qla_pkg::dac_gap_cycles - 1));

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            frame   <= '0;
            cyc     <= '0;
            cmd_lat <= '0;
            shreg   <= '0;
        end else if (!busy) begin
            // start on ready with channel 1 first
            if (data_ready) begin
                busy    <= 1'b1;
                frame   <= '0;
                cyc     <= '0;
                cmd_lat <= cur_cmd;
                shreg   <= make_frame(cur_cmd[0], 2'd0);
            end
        end else if (frame_end) begin
            cyc <= '0;
            if (frame == 2'(qla_pkg::num_chan - 1)) begin
                busy <= 1'b0;
            end else begin
                frame <= frame + 2'd1;
                shreg <= make_frame(cmd_lat[frame + 2'd1], frame + 2'd1);
            end
        end else begin
            cyc <= cyc + 6'd1;
            // shift after the high phase so mosi moves with sclk low
            if (in_frame && cyc[0]) begin
                shreg <= {shreg[qla_pkg::dac_frame_bits-2:0], 1'b0};
            end
        end
    end

    // --------------------
    // serial pins
    // --------------------
    assign csel = ~in_frame;
    assign sclk = in_frame & cyc[0];
    assign mosi = in_frame & shreg[qla_pkg::dac_frame_bits-1];

endmodule

`default_nettype wire

/* read_mux.sv */
// host read multiplexer
// decodes the read address and returns status, timestamp or a
// channel command word in the same cycle; unmapped addresses read 0
`timescale 1ns/1ns
`default_nettype none

module read_mux (
    input  qla_pkg::addr_t    reg_raddr,
    input  qla_pkg::status_t  status,
    input  logic [31:0]       timestamp,
    input  qla_pkg::cmd_set_t cur_cmd,
    output logic [31:0]       reg_rdata
);

    logic main_space;
    logic chan0;

    assign main_space = (reg_raddr.space == qla_pkg::addr_main);
    assign chan0      = (reg_raddr.chan == 4'd0);

    always_comb begin
        reg_rdata = '0;
        if (main_space && chan0) begin
            // board registers on channel 0
            if (reg_raddr.offset == qla_pkg::reg_status) begin
                reg_rdata = status;
            end else if (reg_raddr.offset == qla_pkg::reg_timestamp) begin
                reg_rdata = timestamp;
            end
        end else if (main_space && (reg_raddr.offset == qla_pkg::off_dac_ctrl)) begin
            // zero-extended channel commands
            for (int i = 0; i < qla_pkg::num_chan; i++) begin
                if (reg_raddr.chan == 4'(i + 1)) begin
                    reg_rdata = {16'd0, cur_cmd[i]};
                end
            end
        end
    end

endmodule

`default_nettype wire

/* qla_core.sv */
// motor-controller board core
// host write bus into the command bank and the board status block,
// read mux for host reads, serial shifter towards the quad DAC
`timescale 1ns/1ns
`default_nettype none

module qla_core (
    input  logic           sysclk,
    input  logic           rst_n,
    input  qla_pkg::addr_t reg_raddr,
    input  qla_pkg::addr_t reg_waddr,
    input  logic [31:0]    reg_wdata,
    input  logic           reg_wen,
    input  logic           blk_wen,
    input  logic [3:0]     board_id,
    input  logic [3:0]     amp_fault,
    input  logic           wdog_timeout,
    output logic [31:0]    reg_rdata,
    output logic [31:0]    timestamp,
    output logic           wdog_clear,
    output logic           dac_sclk,
    output logic           dac_mosi,
    output logic           dac_csel
);

    qla_pkg::wr_bus_t  wr;
    qla_pkg::cmd_set_t cur_cmd;
    qla_pkg::status_t  status;
    logic              data_ready;
    logic              dac_busy;

    // --------------------
    // write bus
    // --------------------
    assign wr = '{waddr: reg_waddr, wdata: reg_wdata, wen: reg_wen, blk_wen: blk_wen};

    cmd_bank cmd_bank0 (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .wr         (wr),
        .dac_busy   (dac_busy),
        .cur_cmd    (cur_cmd),
        .data_ready (data_ready)
    );

    board_status board_status0 (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .wr           (wr),
        .board_id     (board_id),
        .amp_fault    (amp_fault),
        .wdog_timeout (wdog_timeout),
        .status       (status),
        .timestamp    (timestamp),
        .wdog_clear   (wdog_clear)
    );

    // --------------------
    // read path and DAC
    // --------------------
    read_mux read_mux0 (
        .reg_raddr (reg_raddr),
        .status    (status),
        .timestamp (timestamp),
        .cur_cmd   (cur_cmd),
        .reg_rdata (reg_rdata)
    );

    dac_shifter dac_shifter0 (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .cur_cmd    (cur_cmd),
        .data_ready (data_ready),
        .busy       (dac_busy),
        .sclk       (dac_sclk),
        .mosi       (dac_mosi),
        .csel       (dac_csel)
    );

endmodule

`default_nettype wire

/* qla_sva.sv */
// DAC serial interface checks, bound into the shifter
// frame length with csel low inside a busy period, sclk toggling
// within a frame, fixed busy length and the ready level dropping
// once shifting starts
`timescale 1ns/1ns
`default_nettype none

module qla_sva (
    input logic sysclk,
    input logic rst_n,
    input logic busy,
    input logic sclk,
    input logic csel,
    input logic data_ready
);

    // four frames of 24 bits at two cycles each, plus the gaps
    localparam int busy_cycles = qla_pkg::num_chan
                                 * (2 * qla_pkg::dac_frame_bits + qla_pkg::dac_gap_cycles);
    // csel low for two cycles per bit
    localparam int frame_cycles = 2 * qla_pkg::dac_frame_bits;

    // cycles of the current busy period
    int busy_len;
    // cycles of the current frame with csel low
    int csel_len;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            busy_len <= 0;
        end else if (busy) begin
            busy_len <= busy_len + 1;
        end else begin
            busy_len <= 0;
        end
    end

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            csel_len <= 0;
        end else if (!csel) begin
            csel_len <= csel_len + 1;
        end else begin
            csel_len <= 0;
        end
    end

    // frame closes inside the busy period after 24 bit times
    csel_in_busy: assert property (@(posedge sysclk) disable iff (!rst_n)
                                   $rose(csel) |-> (busy && (csel_len == frame_cycles)))
        else $error("frame of %0d cycles with csel low", csel_len);

    // sclk flips every cycle while csel stays low
    sclk_toggle: assert property (@(posedge sysclk) disable iff (!rst_n)
                                  (!csel && $past(!csel)) |-> (sclk != $past(sclk)))
        else $error("sclk did not toggle inside a frame");

    busy_length: assert property (@(posedge sysclk) disable iff (!rst_n)
                                  $fell(busy) |-> (busy_len == busy_cycles))
        else $error("busy period of %0d cycles", busy_len);

    // data_ready is the same net as the command bank output
    ready_drop: assert property (@(posedge sysclk) disable iff (!rst_n)
                                 $rose(busy) |=> !data_ready)
        else $error("data_ready still high two cycles after busy rose");

endmodule

bind dac_shifter qla_sva sva0 (
    .sysclk     (sysclk),
    .rst_n      (rst_n),
    .busy       (busy),
    .sclk       (sclk),
    .csel       (csel),
    .data_ready (data_ready)
);

`default_nettype wire

/* tb_qla.sv */
// testbench for the motor-controller board core
// a table of register operations is applied in order; a frame monitor
// collects the DAC serial words, a small register model gives the
// expected command, frame and status values and a cycle count gives
// the expected timestamp
`timescale 1ns/1ns
`default_nettype none

module tb_qla;

    typedef enum logic [2:0] {
        op_cmd,
        op_block,
        op_status,
        op_read,
        op_frames,
        op_stamp
    } op_e;

    // one table row whose data and exp_val meaning depends on op
    typedef struct packed {
        op_e         op;
        logic [3:0]  chan;
        logic        flag;
        logic [31:0] data;
        logic [31:0] exp_val;
    } step_t;

    typedef logic [qla_pkg::dac_frame_bits-1:0] frame_t;

    localparam int period          = 20;
    localparam int cycles_per_step = 300;
    localparam logic [3:0] board_id_val  = 4'ha;
    localparam logic [3:0] amp_fault_val = 4'h6;

    logic           sysclk = 1'b0;
    logic           rst_n;
    qla_pkg::addr_t reg_raddr;
    qla_pkg::addr_t reg_waddr;
    logic [31:0]    reg_wdata;
    logic           reg_wen;
    logic           blk_wen;
    logic [3:0]     board_id;
    logic [3:0]     amp_fault;
    logic           wdog_timeout;
    logic [31:0]    reg_rdata;
    logic [31:0]    timestamp;
    logic           wdog_clear;
    logic           dac_sclk;
    logic           dac_mosi;
    logic           dac_csel;

    // register model
    qla_pkg::cmd_set_t model_cmd;
    logic              model_pwr;
    logic [3:0]        model_amp;
    // cycles since reset release
    logic [31:0]       stamp_model = '0;

    step_t       steps[$];
    frame_t      exp_q[$];
    frame_t      got_q[$];
    frame_t      shift_word;
    int          bit_cnt = 0;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr_state = 32'h73cddc52;

    always #(period / 2) sysclk = ~sysclk;

    always @(posedge sysclk) begin
        if (rst_n) begin
            stamp_model <= stamp_model + 32'd1;
        end
    end

    qla_core dut0 (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .reg_raddr    (reg_raddr),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .blk_wen      (blk_wen),
        .board_id     (board_id),
        .amp_fault    (amp_fault),
        .wdog_timeout (wdog_timeout),
        .reg_rdata    (reg_rdata),
        .timestamp    (timestamp),
        .wdog_clear   (wdog_clear),
        .dac_sclk     (dac_sclk),
        .dac_mosi     (dac_mosi),
        .dac_csel     (dac_csel)
    );

    // --------------------
    // DAC frame monitor
    // --------------------
    // mosi is stable while sclk is high and the MSB arrives first
    always @(posedge dac_sclk) begin
        if (!dac_csel) begin
            shift_word = {shift_word[qla_pkg::dac_frame_bits-2:0], dac_mosi};
            if (bit_cnt == qla_pkg::dac_frame_bits - 1) begin
                got_q.push_back(shift_word);
                bit_cnt = 0;
            end else begin
                bit_cnt = bit_cnt + 1;
            end
        end
    end

    // x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic qla_pkg::cur_cmd_t random_cmd();
        qla_pkg::cur_cmd_t v;
        v = '0;
        for (int i = 0; i < 16; i++) begin
            v = {v[14:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [15:0] cmd_addr(input logic [3:0] chan);
        return {qla_pkg::addr_main, 4'h0, chan, qla_pkg::off_dac_ctrl};
    endfunction

    // status word as the register model sees it
    function automatic qla_pkg::status_t expect_status();
        qla_pkg::status_t s;
        s              = '0;
        s.board_id     = board_id_val;
        s.wdog_timeout = 1'b1;
        s.pwr_enable   = model_pwr;
        s.amp_fault    = amp_fault_val;
        s.amp_enable   = model_amp;
        return s;
    endfunction

    // --------------------
    // checks
    // --------------------
    task automatic compare_cmd(input qla_pkg::cur_cmd_t got, input qla_pkg::cur_cmd_t exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_status(input qla_pkg::status_t got, input qla_pkg::status_t exp,
                                  input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_frame(input frame_t got, input frame_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s was %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s was %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // --------------------
    // bus operations
    // --------------------
    // every task starts and ends 2 ns after a rising edge
    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data, input logic blk);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        blk_wen   = blk;
        @(posedge sysclk);
        #2;
        reg_wen = 1'b0;
        blk_wen = 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
        reg_raddr = addr;
        @(posedge sysclk);
        #2;
        data = reg_rdata;
    endtask

    // one update sends all four channels starting with channel 1
    task automatic push_update();
        for (int i = 0; i < qla_pkg::num_chan; i++) begin
            exp_q.push_back({qla_pkg::dac_cmd_write_update, 2'b00, 2'(i), model_cmd[2'(i)]});
        end
    endtask

    task automatic do_cmd(input logic [3:0] chan, input logic valid);
        qla_pkg::cur_cmd_t value;
        logic [31:0]       rd;
        logic [1:0]        idx;
        value = random_cmd();
        idx   = 2'(chan - 4'd1);
        // single write with blk_wen riding along
        write_reg(cmd_addr(chan), {valid, 15'd0, value}, 1'b1);
        if (valid) begin
            model_cmd[idx] = value;
            push_update();
        end
        read_reg(cmd_addr(chan), rd);
        compare_cmd(rd[15:0], model_cmd[idx], "command read back");
        compare_word(rd, {16'd0, model_cmd[idx]}, "command word zero-extended");
    endtask

    task automatic do_block(input logic while_busy);
        if (while_busy) begin
            // start inside the frames of the previous update
            while (dac_csel) begin
                @(posedge sysclk);
                #2;
            end
        end
        for (int i = 0; i < qla_pkg::num_chan; i++) begin
            model_cmd[2'(i)] = random_cmd();
            write_reg(cmd_addr(4'(i + 1)), {1'b1, 15'd0, model_cmd[2'(i)]}, 1'b0);
        end
        // closing status write with all masks clear
        write_reg(16'h0000, 32'h0, 1'b1);
        push_update();
    endtask

    task automatic do_frames();
        frame_t got;
        frame_t exp;
        while (got_q.size() < exp_q.size()) begin
            @(posedge sysclk);
            #2;
        end
        while (dut0.dac_busy) begin
            @(posedge sysclk);
            #2;
        end
        // a stray update would raise busy within a few cycles
        repeat (4) @(posedge sysclk);
        #2;
        if (dut0.dac_busy) begin
            report_error("DAC update started when none was requested");
        end
        if (got_q.size() != exp_q.size()) begin
            report_error($sformatf("captured %0d DAC frames, expected %0d",
                                   got_q.size(), exp_q.size()));
        end
        while ((got_q.size() > 0) && (exp_q.size() > 0)) begin
            got = got_q.pop_front();
            exp = exp_q.pop_front();
            compare_frame(got, exp, "DAC frame");
        end
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic do_status(input logic [31:0] data, input logic exp_clr);
        logic [31:0]      rd;
        qla_pkg::status_t st;
        logic [3:0]       mask;
        write_reg(16'h0000, data, 1'b0);
        // pulse shows in the cycle after the write
        compare_word({31'd0, wdog_clear}, {31'd0, exp_clr}, "wdog_clear");
        mask = data[qla_pkg::amp_mask_lsb +: 4];
        if (data[qla_pkg::pwr_mask_bit]) begin
            model_pwr = data[qla_pkg::pwr_value_bit];
        end
        // each enable bit follows its value bit only where the mask bit is set
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                model_amp[b] = data[qla_pkg::amp_value_lsb + b];
            end
        end
        read_reg(16'h0000, rd);
        st = rd;
        compare_status(st, expect_status(), "status read");
        compare_word({31'd0, wdog_clear}, 32'd0, "wdog_clear one cycle later");
    endtask

    task automatic do_stamp(input logic [31:0] n);
        logic [31:0] t0;
        logic [31:0] t1;
        read_reg({qla_pkg::addr_main, 4'h0, 4'h0, qla_pkg::reg_timestamp}, t0);
        compare_word(t0, stamp_model, "timestamp read");
        compare_word(timestamp, stamp_model, "timestamp output");
        repeat (n) @(posedge sysclk);
        #2;
        t1 = reg_rdata;
        compare_word(t1 - t0, n, "timestamp difference");
    endtask

    task automatic do_read(input logic [15:0] addr, input logic [31:0] exp_val);
        logic [31:0] rd;
        read_reg(addr, rd);
        compare_word(rd, exp_val, $sformatf("read of %h", addr));
    endtask

    // --------------------
    // stimulus table
    // --------------------
    task automatic add_step(input op_e op, input logic [3:0] chan, input logic flag,
                            input logic [31:0] data, input logic [31:0] exp_val);
        steps.push_back('{op, chan, flag, data, exp_val});
    endtask

    task automatic load_table();
        // op         chan  flag  data           exp_val
        add_step(op_cmd,    4'd2, 1'b1, 32'h0,         32'h0);
        add_step(op_frames, 4'd0, 1'b0, 32'h0,         32'h0);
        // invalid command starts no frames
        add_step(op_cmd,    4'd3, 1'b0, 32'h0,         32'h0);
        add_step(op_frames, 4'd0, 1'b0, 32'h0,         32'h0);
        // second block lands while the first is shifting
        add_step(op_block,  4'd0, 1'b0, 32'h0,         32'h0);
        add_step(op_block,  4'd0, 1'b1, 32'h0,         32'h0);
        add_step(op_frames, 4'd0, 1'b0, 32'h0,         32'h0);
        // flag is the expected wdog_clear pulse
        add_step(op_status, 4'd0, 1'b1, 32'h000c_0505, 32'h0);
        add_step(op_status, 4'd0, 1'b0, 32'h0000_0300, 32'h0);
        add_step(op_status, 4'd0, 1'b0, 32'h0008_000f, 32'h0);
        add_step(op_stamp,  4'd0, 1'b0, 32'd37,        32'h0);
        add_step(op_read,   4'd0, 1'b0, 32'h0000_1001, 32'h0);
        add_step(op_read,   4'd0, 1'b0, 32'h0000_0051, 32'h0);
        add_step(op_read,   4'd0, 1'b0, 32'h0000_0003, 32'h0);
        add_step(op_cmd,    4'd4, 1'b1, 32'h0,         32'h0);
        add_step(op_frames, 4'd0, 1'b0, 32'h0,         32'h0);
    endtask

    initial begin
        op_e op;
        int  err_before;
        rst_n        = 1'b0;
        reg_raddr    = '0;
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_wen      = 1'b0;
        blk_wen      = 1'b0;
        board_id     = board_id_val;
        amp_fault    = amp_fault_val;
        wdog_timeout = 1'b1;
        model_cmd    = '0;
        model_pwr    = 1'b0;
        model_amp    = '0;
        load_table();
        repeat (2) @(posedge sysclk);
        #2;
        rst_n = 1'b1;
        @(posedge sysclk);
        #2;
        for (int i = 0; i < steps.size(); i++) begin
            op         = steps[i].op;
            err_before = errors;
            case (op)
                op_cmd:    do_cmd(steps[i].chan, steps[i].flag);
                op_block:  do_block(steps[i].flag);
                op_status: do_status(steps[i].data, steps[i].flag);
                op_read:   do_read(steps[i].data[15:0], steps[i].exp_val);
                op_frames: do_frames();
                op_stamp:  do_stamp(steps[i].data);
                default:   report_error("unknown operation in the table");
            endcase
            $display("test %0d %s: %s", i, op.name(), (errors == err_before) ? "ok" : "errors");
        end
        $display("%0d tests, %0d checks, %0d errors", steps.size(), checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog starts once the table is filled at time zero
    initial begin
        #1;
        #(steps.size() * cycles_per_step * period);
        $display("timeout: table not finished after %0d cycles", steps.size() * cycles_per_step);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
qla_pkg.sv
cmd_bank.sv
board_status.sv
dac_shifter.sv
read_mux.sv
qla_core.sv
qla_sva.sv
tb_qla.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_qla
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell cat $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
